/* source/fabric_pkg.sv */
// ====================
// shared widths, default timing constants and enums
// for the fabric logic beside the processor system
// ====================

package fabric_pkg;

  // ====================
  // port widths
  // ====================
  localparam int key_w       = 2;   // push keys
  localparam int sw_w        = 4;   // slide switches
  localparam int reset_req_w = 3;   // cold, warm, debug request lines
  localparam int stm_event_w = 28;  // trace-event vector
  localparam int led_pio_w   = 7;   // led pio field, tied to zero now

  // ====================
  // default timing, in 50 MHz cycles
  // ====================
  localparam int def_debounce_timeout = 50000;  // 1 ms
  localparam int def_cold_pulse_len   = 6;
  localparam int def_warm_pulse_len   = 2;
  localparam int def_debug_pulse_len  = 32;
  localparam int def_heartbeat_half   = 25000000;  // 0.5 s, so 1 Hz blink

  // index of each line on the request bus
  typedef enum logic [1:0]
  {
    req_cold  = 2'd0,
    req_warm  = 2'd1,
    req_debug = 2'd2
  } reset_req_e;

  // pulse stretcher state
  typedef enum logic
  {
    pulse_idle = 1'b0,  // waiting for a rising edge
    pulse_busy = 1'b1   // output held low, new edges dropped
  } pulse_state_e;

endpackage : fabric_pkg

/* source/key_debounce.sv */
// ====================
// push key debouncer, one synchronizer and
// one timeout counter per key
// ====================

module key_debounce
#(
  parameter int width   = fabric_pkg::key_w,
  parameter int timeout = fabric_pkg::def_debounce_timeout
)
(
  input  logic             fpga_clk_50,
  input  logic             hps_fpga_reset_n,
  input  logic [width-1:0] keys,            // raw, active low
  output logic [width-1:0] debounced_keys
);

  // counter only has to reach timeout-1
  localparam int cnt_w = $clog2(timeout + 1);

  logic [width-1:0] key_meta;  // first sync stage
  logic [width-1:0] key_sync;  // second sync stage

  // ====================
  // input synchronizer
  // ====================
  // keys idle high, so sync flops come out of reset at ones
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= keys;
      key_sync <= key_meta;
    end
  end

  // ====================
  // per key timeout
  // ====================
  for (genvar i = 0; i < width; i++)
  begin : g_key
    logic [cnt_w-1:0] cnt;    // cycles the new level has held
    logic             key_q;  // debounced level of this key

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        cnt   <= '0;
        key_q <= 1'b1;  // released
      end
      else if (key_sync[i] == key_q)
        cnt <= '0;  // glitch gone, start over
      else if (cnt == cnt_w'(timeout - 1))
      begin
        // level held long enough
        key_q <= key_sync[i];
        cnt   <= '0;
      end
      else
        cnt <= cnt + 1'b1;
    end

    assign debounced_keys[i] = key_q;
  end

endmodule : key_debounce

/* source/reset_pulse.sv */
// ====================
// rising edge to fixed length active low pulse,
// edges during a pulse are dropped
// ====================

module reset_pulse
#(
  parameter int pulse_len = fabric_pkg::def_cold_pulse_len
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic level,     // already synchronized
  output logic pulse_n
);

  // holds 0 .. pulse_len-1
  localparam int cnt_w = $clog2(pulse_len + 1);

  fabric_pkg::pulse_state_e state;

  logic             level_q;  // previous level
  logic             rise;
  logic [cnt_w-1:0] cnt;      // low cycles already spent

  assign rise = level & ~level_q;

  // edge history runs even while busy
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      level_q <= 1'b0;
    else
      level_q <= level;
  end

  // ====================
  // stretcher FSM
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state   <= fabric_pkg::pulse_idle;
      cnt     <= '0;
      pulse_n <= 1'b1;  // reset request inactive
    end
    else
    begin
      case (state)
        fabric_pkg::pulse_idle:
        begin
          if (rise)
          begin
            state   <= fabric_pkg::pulse_busy;
            cnt     <= '0;
            pulse_n <= 1'b0;  // low from the next cycle on
          end
        end
        fabric_pkg::pulse_busy:
        begin
          // rise is not looked at here
          if (cnt == cnt_w'(pulse_len - 1))
          begin
            state   <= fabric_pkg::pulse_idle;
            pulse_n <= 1'b1;
          end
          else
            cnt <= cnt + 1'b1;
        end
        default: state <= fabric_pkg::pulse_idle;
      endcase
    end
  end

endmodule : reset_pulse

/* source/reset_request_ctrl.sv */
// ====================
// reset request synchronizer and the
// cold, warm and debug pulse stretchers
// ====================

module reset_request_ctrl
#(
  parameter int cold_len  = fabric_pkg::def_cold_pulse_len,
  parameter int warm_len  = fabric_pkg::def_warm_pulse_len,
  parameter int debug_len = fabric_pkg::def_debug_pulse_len
)
(
  input  logic                               fpga_clk_50,
  input  logic                               hps_fpga_reset_n,
  input  logic [fabric_pkg::reset_req_w-1:0] reset_req,
  output logic                               cold_reset_n,
  output logic                               warm_reset_n,
  output logic                               debug_reset_n
);

  logic [fabric_pkg::reset_req_w-1:0] req_meta;
  logic [fabric_pkg::reset_req_w-1:0] req_sync;  // two cycles behind reset_req

  // request levels come from another domain
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_meta <= '0;
      req_sync <= '0;
    end
    else
    begin
      req_meta <= reset_req;
      req_sync <= req_meta;
    end
  end

  // one stretcher per line, each with its own length
  reset_pulse #(.pulse_len(cold_len)) pulse_cold
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .level            (req_sync[fabric_pkg::req_cold]),
    .pulse_n          (cold_reset_n)
  );

  reset_pulse #(.pulse_len(warm_len)) pulse_warm
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .level            (req_sync[fabric_pkg::req_warm]),
    .pulse_n          (warm_reset_n)
  );

  reset_pulse #(.pulse_len(debug_len)) pulse_debug
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .level            (req_sync[fabric_pkg::req_debug]),
    .pulse_n          (debug_reset_n)
  );

endmodule : reset_request_ctrl

/* source/heartbeat.sv */
// ====================
// heartbeat LED blinker
// ====================

module heartbeat
#(
  parameter int half_period = 25000000  // cycles per LED level
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led
);

  localparam int cnt_w = $clog2(half_period + 1);

  logic [cnt_w-1:0] cnt;

  // wrap at half_period-1, flip the LED on each wrap
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt <= '0;
      led <= 1'b0;  // LED off
    end
    else if (cnt == cnt_w'(half_period - 1))
    begin
      cnt <= '0;
      led <= ~led;
    end
    else
      cnt <= cnt + 1'b1;
  end

endmodule : heartbeat

/* source/ghrd_fabric_top.sv */
// ====================
// fabric top level: key debounce, reset request
// pulses, heartbeat and trace-event vector
// ====================

module ghrd_fabric_top
#(
  parameter int debounce_timeout = fabric_pkg::def_debounce_timeout,
  parameter int cold_pulse_len   = fabric_pkg::def_cold_pulse_len,
  parameter int warm_pulse_len   = fabric_pkg::def_warm_pulse_len,
  parameter int debug_pulse_len  = fabric_pkg::def_debug_pulse_len,
  parameter int heartbeat_half   = fabric_pkg::def_heartbeat_half
)
(
  input  logic                               fpga_clk_50,
  input  logic                               hps_fpga_reset_n,
  input  logic [fabric_pkg::key_w-1:0]       key,            // active low
  input  logic [fabric_pkg::sw_w-1:0]        sw,
  input  logic [fabric_pkg::reset_req_w-1:0] hps_reset_req,  // cold, warm, debug
  output logic                               heartbeat_led,
  output logic                               hps_cold_reset_n,
  output logic                               hps_warm_reset_n,
  output logic                               hps_debug_reset_n,
  output logic [fabric_pkg::stm_event_w-1:0] stm_hw_events
);

  // zero bits above the switch field
  localparam int pad_w = fabric_pkg::stm_event_w - fabric_pkg::sw_w
                       - fabric_pkg::led_pio_w - fabric_pkg::key_w;

  logic [fabric_pkg::key_w-1:0] debounced_keys;

  // ====================
  // blocks
  // ====================
  key_debounce
  #(
    .width   (fabric_pkg::key_w),
    .timeout (debounce_timeout)
  )
  u_key_debounce
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .keys             (key),
    .debounced_keys   (debounced_keys)
  );

  reset_request_ctrl
  #(
    .cold_len  (cold_pulse_len),
    .warm_len  (warm_pulse_len),
    .debug_len (debug_pulse_len)
  )
  u_reset_request_ctrl
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .reset_req        (hps_reset_req),
    .cold_reset_n     (hps_cold_reset_n),
    .warm_reset_n     (hps_warm_reset_n),
    .debug_reset_n    (hps_debug_reset_n)
  );

  heartbeat #(.half_period(heartbeat_half)) u_heartbeat
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led              (heartbeat_led)
  );

  // event vector, switches go in unsynchronized
  // led pio field stays zero, kept for the bit layout
  assign stm_hw_events = {{pad_w{1'b0}}, sw, {fabric_pkg::led_pio_w{1'b0}}, debounced_keys};

endmodule : ghrd_fabric_top

/* test/tb_ghrd_fabric.sv */
// ====================
// fabric top level testbench with reference
// functions and checks of reset state, key debounce,
// reset pulses, heartbeat and switch field
// ====================

module tb_ghrd_fabric;

  timeunit 1ns;
  timeprecision 100ps;

  // short timing so the run stays small
  localparam int debounce_cycles = 20;
  localparam int cold_cycles     = 6;
  localparam int warm_cycles     = 2;
  localparam int debug_cycles    = 32;
  localparam int half_cycles     = 50;

  logic        fpga_clk_50;
  logic        hps_fpga_reset_n;
  logic [1:0]  key;               // active low
  logic [3:0]  sw;
  logic [2:0]  hps_reset_req;     // cold, warm, debug
  logic        heartbeat_led;
  logic        hps_cold_reset_n;
  logic        hps_warm_reset_n;
  logic        hps_debug_reset_n;
  logic [27:0] stm_hw_events;

  int    err_count;
  int    check_count;
  int    tests_run;
  int    tests_failed;
  int    test_err_start;  // error count when the test began
  string test_name;

  ghrd_fabric_top
  #(
    .debounce_timeout (debounce_cycles),
    .cold_pulse_len   (cold_cycles),
    .warm_pulse_len   (warm_cycles),
    .debug_pulse_len  (debug_cycles),
    .heartbeat_half   (half_cycles)
  )
  dut0
  (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .hps_reset_req     (hps_reset_req),
    .heartbeat_led     (heartbeat_led),
    .hps_cold_reset_n  (hps_cold_reset_n),
    .hps_warm_reset_n  (hps_warm_reset_n),
    .hps_debug_reset_n (hps_debug_reset_n),
    .stm_hw_events     (stm_hw_events)
  );

  always #2 fpga_clk_50 = ~fpga_clk_50;  // 4 ns period

  // ====================
  // reference model
  // ====================
  // 15 zeros, switches, 7 zeros of led pio, debounced keys
  function automatic logic [27:0] exp_events(input logic [3:0] sw_val, input logic [1:0] key_val);
    return {15'd0, sw_val, 7'd0, key_val};
  endfunction

  function automatic int exp_pulse_len(input int line);
    case (line)
      0:       return cold_cycles;
      1:       return warm_cycles;
      default: return debug_cycles;
    endcase
  endfunction

  function automatic int exp_toggle_period();
    return half_cycles;  // one LED level
  endfunction

  // 0..2 reset outputs, 3 heartbeat, 4..5 debounced keys
  function automatic logic probe(input int sel);
    case (sel)
      0:       return hps_cold_reset_n;
      1:       return hps_warm_reset_n;
      2:       return hps_debug_reset_n;
      3:       return heartbeat_led;
      4:       return stm_hw_events[0];
      default: return stm_hw_events[1];
    endcase
  endfunction

  // ====================
  // helpers
  // ====================
  task automatic tick();
    @(posedge fpga_clk_50);
    #1;  // drive point with outputs already settled
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      err_count++;
      $display("Mismatch %s (%s): expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic check_range(input string what, input int lo, input int hi, input int actual);
    check_count++;
    if (actual < lo || actual > hi)
    begin
      err_count++;
      $display("Mismatch %s (%s): expected %0d to %0d, actual %0d",
               test_name, what, lo, hi, actual);
    end
  endtask

  // bounded wait for one probed output to reach a level
  task automatic wait_level(input int sel, input logic val, input int limit,
                            input string what, output int waited);
    waited = 0;
    while (probe(sel) !== val && waited < limit)
    begin
      tick();
      waited++;
    end
    if (probe(sel) !== val)
    begin
      err_count++;
      $display("Timeout: %s did not happen within %0d cycles", what, limit);
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = err_count;
    tests_run++;
  endtask

  task automatic end_test();
    if (err_count == test_err_start)
      $display("test %s: ok", test_name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, err_count - test_err_start);
    end
  endtask

  // ====================
  // stimulus tasks
  // ====================
  // short low bursts on both keys leave the field released
  task automatic glitch_keys(input int count);
    int len;
    for (int g = 0; g < count; g++)
    begin
      len = 1 + int'($urandom % (debounce_cycles - 1));  // 1..19 cycles
      key = 2'b00;
      for (int c = 0; c < len; c++)
      begin
        tick();
        check_value("key glitch", 32'(2'b11), 32'(stm_hw_events[1:0]));
      end
      key = 2'b11;
      for (int c = 0; c < debounce_cycles + 5; c++)
      begin
        tick();
        check_value("key glitch", 32'(2'b11), 32'(stm_hw_events[1:0]));
      end
    end
  endtask

  // press one key for 40 cycles and release it
  task automatic press_release(input int k);
    logic [1:0] pressed;
    int         waited;
    pressed    = 2'b11;
    pressed[k] = 1'b0;
    key        = pressed;
    wait_level(4 + k, 1'b0, debounce_cycles + 4, "debounced press", waited);
    check_range("press latency", debounce_cycles + 2, debounce_cycles + 4, waited);
    check_value("press field", 32'(exp_events(sw, pressed)), 32'(stm_hw_events));
    for (int c = waited; c < 40; c++)
      tick();
    key = 2'b11;
    wait_level(4 + k, 1'b1, debounce_cycles + 4, "debounced release", waited);
    check_range("release latency", debounce_cycles + 2, debounce_cycles + 4, waited);
    check_value("release field", 32'(exp_events(sw, 2'b11)), 32'(stm_hw_events));
  endtask

  // optional second rising edge gap cycles after the first
  task automatic retrigger(input int line, input int gap, input int since);
    if (gap > 0 && since == gap / 2)
      hps_reset_req[line] = 1'b0;
    if (gap > 0 && since == gap)
      hps_reset_req[line] = 1'b1;
  endtask

  task automatic measure_pulse(input int line, input int gap);
    int since;    // cycles since the request rose
    int low_len;
    since               = 0;
    low_len             = 0;
    hps_reset_req[line] = 1'b1;
    while (probe(line) !== 1'b0 && since < 5)
    begin
      tick();
      since++;
      retrigger(line, gap, since);
    end
    if (probe(line) !== 1'b0)
    begin
      err_count++;
      $display("Timeout: reset pulse on line %0d did not start within 5 cycles", line);
    end
    else
    begin
      check_range("pulse start", 3, 5, since);
      while (probe(line) === 1'b0 && low_len < 2 * debug_cycles)
      begin
        tick();
        since++;
        low_len++;
        retrigger(line, gap, since);
      end
      check_value("pulse length", 32'(exp_pulse_len(line)), 32'(low_len));
      // no second pulse while the request stays high
      for (int c = 0; c < 40; c++)
      begin
        tick();
        check_value("pulse idle", 32'(1'b1), 32'(probe(line)));
      end
    end
    hps_reset_req[line] = 1'b0;
    repeat (4) tick();  // let the synchronizer drain
  endtask

  // ====================
  // main sequence
  // ====================
  initial
  begin
    logic cur;
    int   waited;
    void'($urandom(33));
    fpga_clk_50      = 1'b0;
    hps_fpga_reset_n = 1'b0;
    key              = 2'b11;  // released
    sw               = 4'($urandom);
    hps_reset_req    = 3'b000;
    err_count        = 0;
    check_count      = 0;
    tests_run        = 0;
    tests_failed     = 0;
    repeat (4) @(posedge fpga_clk_50);
    #1;
    hps_fpga_reset_n = 1'b1;
    tick();

    start_test("reset state");
    check_value("reset heartbeat", 32'(1'b0), 32'(heartbeat_led));
    check_value("reset outputs", 32'(3'b111),
                32'({hps_debug_reset_n, hps_warm_reset_n, hps_cold_reset_n}));
    check_value("reset events", 32'(exp_events(sw, 2'b11)), 32'(stm_hw_events));
    end_test();

    start_test("debounce");
    glitch_keys(6);
    press_release(0);
    press_release(1);
    end_test();

    start_test("reset pulses");
    for (int line = 0; line < 3; line++)
      measure_pulse(line, 0);
    end_test();

    start_test("busy rule");
    measure_pulse(2, 10);
    end_test();

    start_test("heartbeat");
    cur = heartbeat_led;
    wait_level(3, ~cur, half_cycles + 2, "first heartbeat toggle", waited);
    for (int t = 0; t < 4; t++)
    begin
      cur = heartbeat_led;
      wait_level(3, ~cur, half_cycles + 10, "heartbeat toggle", waited);
      check_value("heartbeat period", 32'(exp_toggle_period()), 32'(waited));
    end
    end_test();

    start_test("switch field");
    for (int i = 0; i < 8; i++)
    begin
      sw = 4'($urandom);
      tick();
      check_value("switch field", 32'(exp_events(sw, 2'b11)), 32'(stm_hw_events));
    end
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule : tb_ghrd_fabric

/* build.f */
source/fabric_pkg.sv
source/key_debounce.sv
source/reset_pulse.sv
source/reset_request_ctrl.sv
source/heartbeat.sv
source/ghrd_fabric_top.sv
test/tb_ghrd_fabric.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f build.f \
  --top-module tb_ghrd_fabric \
  -o sim_tb

./obj_dir/sim_tb > "$LOG" 2>&1
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
